// ==== rtl/apb_pkg.sv ====
package apb_pkg;

    // ########################################
    // bus types
    // ########################################
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] pdata_t;
    typedef logic [3:0]  pstrb_t;
    typedef logic [2:0]  pprot_t;

    // slow-down ratio and delay counting
    typedef logic [7:0]  ratio_t;
    typedef logic [15:0] delay_cnt_t;

    // ########################################
    // address map
    // ########################################
    localparam logic [3:0] SLOW_NIBBLE_LO = 4'hA;
    localparam logic [3:0] SLOW_NIBBLE_HI = 4'hB;

    localparam paddr_t MEM_BASE  = 32'hA000_0000;
    localparam int     MEM_WORDS = 64;

    localparam paddr_t CFG_BASE      = 32'h1000_0000;
    localparam paddr_t CFG_RATIO_OFS = 32'h0000_0000;
    localparam paddr_t CFG_HITS_OFS  = 32'h0000_0004;

    // register defaults and queue sizing
    localparam ratio_t RATIO_RESET = 8'd8;
    localparam int     CMD_DEPTH   = 4;
    localparam int     CMD_PTR_W   = $clog2(CMD_DEPTH);

endpackage

// ==== rtl/apb_cmd_master.sv ====
module apb_cmd_master (
    input  logic            clock,
    input  logic            reset,
    input  logic            cmd_valid,
    input  logic            cmd_write,
    input  apb_pkg::paddr_t cmd_addr,
    input  apb_pkg::pdata_t cmd_wdata,
    input  apb_pkg::pstrb_t cmd_strb,
    output logic            cmd_credit,
    output logic            rsp_valid,
    output apb_pkg::pdata_t rsp_rdata,
    output logic            rsp_error,
    output apb_pkg::paddr_t m_paddr,
    output logic            m_psel,
    output logic            m_penable,
    output logic            m_pwrite,
    output apb_pkg::pdata_t m_pwdata,
    output apb_pkg::pstrb_t m_pstrb,
    output apb_pkg::pprot_t m_pprot,
    input  logic            m_pready,
    input  apb_pkg::pdata_t m_prdata,
    input  logic            m_pslverr
);
    import apb_pkg::*;

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_t;

    state_t               state;
    logic                 q_write [CMD_DEPTH];
    paddr_t               q_addr  [CMD_DEPTH];
    pdata_t               q_wdata [CMD_DEPTH];
    pstrb_t               q_strb  [CMD_DEPTH];
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_PTR_W:0]   q_count;
    logic [CMD_PTR_W:0]   credits;
    logic                 push;
    logic                 pop;
    logic                 done;

    assign push = cmd_valid;
    assign done = state == ACCESS && m_pready;
    assign pop  = q_count != '0 && (state == IDLE || done);

    // ########################################
    // command queue
    // ########################################
    always_ff @(posedge clock) begin
        if (push) begin
            q_write[wr_ptr] <= cmd_write;
            q_addr[wr_ptr]  <= cmd_addr;
            q_wdata[wr_ptr] <= cmd_wdata;
            q_strb[wr_ptr]  <= cmd_strb;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_count <= q_count + (CMD_PTR_W+1)'(push) - (CMD_PTR_W+1)'(pop);
        end
    end

    // ########################################
    // APB master
    // ########################################
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (pop) state <= SETUP;
                SETUP:   state <= ACCESS;
                ACCESS:  if (done) state <= pop ? SETUP : IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            m_paddr  <= q_addr[rd_ptr];
            m_pwrite <= q_write[rd_ptr];
            m_pwdata <= q_wdata[rd_ptr];
            m_pstrb  <= q_strb[rd_ptr];
        end
    end

    assign m_psel    = state != IDLE;
    assign m_penable = state == ACCESS;
    // normal, secure, data access
    assign m_pprot   = '0;

    // response and credit one cycle after pready
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rsp_valid  <= 1'b0;
            rsp_error  <= 1'b0;
            cmd_credit <= 1'b0;
        end else begin
            rsp_valid  <= done;
            rsp_error  <= done && m_pslverr;
            cmd_credit <= done;
        end
    end

    always_ff @(posedge clock) begin
        if (done) begin
            rsp_rdata <= m_pwrite ? '0 : m_prdata;
        end
    end

    // credits held by the source
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credits <= (CMD_PTR_W+1)'(CMD_DEPTH);
        end else begin
            credits <= credits - (CMD_PTR_W+1)'(push) + (CMD_PTR_W+1)'(cmd_credit);
        end
    end

    a_cmd_has_credit: assert property (@(posedge clock) disable iff (reset)
        cmd_valid |-> (credits != '0 || cmd_credit));

    a_queue_no_overflow: assert property (@(posedge clock) disable iff (reset)
        push && q_count == CMD_DEPTH |-> pop);

endmodule

// ==== rtl/apb_delayer.sv ====
module apb_delayer (
    input  logic            clock,
    input  logic            reset,
    input  apb_pkg::paddr_t m_paddr,
    input  logic            m_psel,
    input  logic            m_penable,
    input  logic            m_pwrite,
    input  apb_pkg::pdata_t m_pwdata,
    input  apb_pkg::pstrb_t m_pstrb,
    input  apb_pkg::pprot_t m_pprot,
    output logic            m_pready,
    output apb_pkg::pdata_t m_prdata,
    output logic            m_pslverr,
    input  apb_pkg::ratio_t ratio,
    output apb_pkg::paddr_t s_paddr,
    output logic            s_psel,
    output logic            s_penable,
    output logic            s_pwrite,
    output apb_pkg::pdata_t s_pwdata,
    output apb_pkg::pstrb_t s_pstrb,
    output apb_pkg::pprot_t s_pprot,
    input  logic            s_pready,
    input  apb_pkg::pdata_t s_prdata,
    input  logic            s_pslverr,
    output logic            delay_hit
);
    import apb_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, WAIT} state_t;

    state_t     state;
    delay_cnt_t cnt;
    ratio_t     ratio_m1;
    pdata_t     rdata_q;
    logic       pslverr_q;
    logic       slow_addr;
    logic       start_slow;
    logic       release_rsp;

    // request side is untouched
    assign s_paddr   = m_paddr;
    assign s_psel    = m_psel;
    assign s_penable = m_penable;
    assign s_pwrite  = m_pwrite;
    assign s_pwdata  = m_pwdata;
    assign s_pstrb   = m_pstrb;
    assign s_pprot   = m_pprot;

    assign slow_addr   = m_paddr[31:28] >= SLOW_NIBBLE_LO && m_paddr[31:28] <= SLOW_NIBBLE_HI;
    assign start_slow  = state == IDLE && m_psel && !m_penable && slow_addr;
    // ratio 0 behaves like 1
    assign ratio_m1    = (ratio == '0) ? '0 : ratio - 1'b1;
    assign release_rsp = state == WAIT && cnt == '0;

    // ########################################
    // wait measurement and stretch
    // ########################################
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (start_slow) state <= REQ;
                end
                REQ: begin
                    if (s_pready) begin
                        state <= WAIT;
                        cnt   <= delay_cnt_t'(ratio_m1) * (cnt + 1'b1);
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                WAIT: begin
                    if (cnt == '0) state <= IDLE;
                    else cnt <= cnt - 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // captured device reply
    always_ff @(posedge clock) begin
        if (state == REQ && s_pready) begin
            rdata_q   <= s_prdata;
            pslverr_q <= s_pslverr;
        end
    end

    assign m_pready  = (state == IDLE) ? s_pready : release_rsp;
    assign m_prdata  = (state == IDLE) ? s_prdata : rdata_q;
    assign m_pslverr = (state == IDLE) ? s_pslverr : pslverr_q;
    assign delay_hit = release_rsp;

    // master must hold the slow access phase while the reply is hidden
    a_hold_access: assert property (@(posedge clock) disable iff (reset)
        state != IDLE |-> m_psel && m_penable && slow_addr);

endmodule

// ==== rtl/delay_config.sv ====
module delay_config (
    input  logic            clock,
    input  logic            reset,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  apb_pkg::paddr_t paddr,
    input  apb_pkg::pdata_t pwdata,
    input  logic            delay_hit,
    output logic            pready,
    output apb_pkg::pdata_t prdata,
    output logic            pslverr,
    output apb_pkg::ratio_t ratio
);
    import apb_pkg::*;

    pdata_t hits;
    logic   access;
    logic   ratio_sel;
    logic   hits_sel;

    assign access    = psel && penable;
    assign ratio_sel = paddr[27:0] == CFG_RATIO_OFS[27:0];
    assign hits_sel  = paddr[27:0] == CFG_HITS_OFS[27:0];

    // no wait states
    assign pready  = access;
    assign pslverr = access && !(ratio_sel || hits_sel);
    assign prdata  = ratio_sel ? pdata_t'(ratio) : hits_sel ? hits : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ratio <= RATIO_RESET;
        end else if (access && pwrite && ratio_sel) begin
            ratio <= pwdata[$bits(ratio_t)-1:0];
        end
    end

    // any write clears the count
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hits <= '0;
        end else if (access && pwrite && hits_sel) begin
            hits <= '0;
        end else if (delay_hit) begin
            hits <= hits + 1'b1;
        end
    end

endmodule

// ==== rtl/apb_mem_slave.sv ====
module apb_mem_slave (
    input  logic            clock,
    input  logic            reset,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  apb_pkg::paddr_t paddr,
    input  apb_pkg::pdata_t pwdata,
    input  apb_pkg::pstrb_t pstrb,
    output logic            pready,
    output apb_pkg::pdata_t prdata,
    output logic            pslverr
);
    import apb_pkg::*;

    pdata_t                       mem [MEM_WORDS];
    logic                         access;
    logic                         wait_done;
    logic                         in_range;
    logic [$clog2(MEM_WORDS)-1:0] idx;

    assign access   = psel && penable;
    assign in_range = paddr[27:2] < MEM_WORDS;
    assign idx      = paddr[$clog2(MEM_WORDS)+1:2];

    // one wait state
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wait_done <= 1'b0;
        end else begin
            wait_done <= access;
        end
    end

    assign pready  = access && wait_done;
    assign pslverr = pready && !in_range;
    assign prdata  = in_range ? mem[idx] : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (pready && pwrite && in_range) begin
            for (int b = 0; b < $bits(pstrb_t); b++) begin
                if (pstrb[b]) begin
                    mem[idx][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== rtl/apb_decoder.sv ====
module apb_decoder (
    input  apb_pkg::paddr_t s_paddr,
    input  logic            s_psel,
    input  logic            s_penable,
    output logic            s_pready,
    output apb_pkg::pdata_t s_prdata,
    output logic            s_pslverr,
    output logic            cfg_psel,
    input  logic            cfg_pready,
    input  apb_pkg::pdata_t cfg_prdata,
    input  logic            cfg_pslverr,
    output logic            mem_psel,
    input  logic            mem_pready,
    input  apb_pkg::pdata_t mem_prdata,
    input  logic            mem_pslverr
);
    import apb_pkg::*;

    logic cfg_hit;
    logic mem_hit;

    assign cfg_hit  = s_paddr[31:28] == CFG_BASE[31:28];
    assign mem_hit  = s_paddr[31:28] == MEM_BASE[31:28];
    assign cfg_psel = s_psel && cfg_hit;
    assign mem_psel = s_psel && mem_hit;

    // unmapped gets an immediate error
    always_comb begin
        if (cfg_hit) begin
            s_pready  = cfg_pready;
            s_prdata  = cfg_prdata;
            s_pslverr = cfg_pslverr;
        end else if (mem_hit) begin
            s_pready  = mem_pready;
            s_prdata  = mem_prdata;
            s_pslverr = mem_pslverr;
        end else begin
            s_pready  = 1'b1;
            s_prdata  = '0;
            s_pslverr = s_psel && s_penable;
        end
    end

endmodule

// ==== rtl/apb_subsys_top.sv ====
module apb_subsys_top (
    input  logic            clock,
    input  logic            reset,
    input  logic            cmd_valid,
    input  logic            cmd_write,
    input  apb_pkg::paddr_t cmd_addr,
    input  apb_pkg::pdata_t cmd_wdata,
    input  apb_pkg::pstrb_t cmd_strb,
    output logic            cmd_credit,
    output logic            rsp_valid,
    output apb_pkg::pdata_t rsp_rdata,
    output logic            rsp_error
);
    import apb_pkg::*;

    // master side segment
    paddr_t m_paddr;
    logic   m_psel;
    logic   m_penable;
    logic   m_pwrite;
    pdata_t m_pwdata;
    pstrb_t m_pstrb;
    pprot_t m_pprot;
    logic   m_pready;
    pdata_t m_prdata;
    logic   m_pslverr;

    // device side segment
    paddr_t s_paddr;
    logic   s_psel;
    logic   s_penable;
    logic   s_pwrite;
    pdata_t s_pwdata;
    pstrb_t s_pstrb;
    logic   s_pready;
    pdata_t s_prdata;
    logic   s_pslverr;

    logic   cfg_psel;
    logic   cfg_pready;
    pdata_t cfg_prdata;
    logic   cfg_pslverr;
    logic   mem_psel;
    logic   mem_pready;
    pdata_t mem_prdata;
    logic   mem_pslverr;
    ratio_t ratio;
    logic   delay_hit;

    apb_cmd_master u_master (
        .clock      (clock),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_write  (cmd_write),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .cmd_strb   (cmd_strb),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_error  (rsp_error),
        .m_paddr    (m_paddr),
        .m_psel     (m_psel),
        .m_penable  (m_penable),
        .m_pwrite   (m_pwrite),
        .m_pwdata   (m_pwdata),
        .m_pstrb    (m_pstrb),
        .m_pprot    (m_pprot),
        .m_pready   (m_pready),
        .m_prdata   (m_prdata),
        .m_pslverr  (m_pslverr)
    );

    apb_delayer u_delayer (
        .clock     (clock),
        .reset     (reset),
        .m_paddr   (m_paddr),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_pwrite  (m_pwrite),
        .m_pwdata  (m_pwdata),
        .m_pstrb   (m_pstrb),
        .m_pprot   (m_pprot),
        .m_pready  (m_pready),
        .m_prdata  (m_prdata),
        .m_pslverr (m_pslverr),
        .ratio     (ratio),
        .s_paddr   (s_paddr),
        .s_psel    (s_psel),
        .s_penable (s_penable),
        .s_pwrite  (s_pwrite),
        .s_pwdata  (s_pwdata),
        .s_pstrb   (s_pstrb),
        .s_pprot   (),
        .s_pready  (s_pready),
        .s_prdata  (s_prdata),
        .s_pslverr (s_pslverr),
        .delay_hit (delay_hit)
    );

    apb_decoder u_decoder (
        .s_paddr     (s_paddr),
        .s_psel      (s_psel),
        .s_penable   (s_penable),
        .s_pready    (s_pready),
        .s_prdata    (s_prdata),
        .s_pslverr   (s_pslverr),
        .cfg_psel    (cfg_psel),
        .cfg_pready  (cfg_pready),
        .cfg_prdata  (cfg_prdata),
        .cfg_pslverr (cfg_pslverr),
        .mem_psel    (mem_psel),
        .mem_pready  (mem_pready),
        .mem_prdata  (mem_prdata),
        .mem_pslverr (mem_pslverr)
    );

    delay_config u_config (
        .clock     (clock),
        .reset     (reset),
        .psel      (cfg_psel),
        .penable   (s_penable),
        .pwrite    (s_pwrite),
        .paddr     (s_paddr),
        .pwdata    (s_pwdata),
        .delay_hit (delay_hit),
        .pready    (cfg_pready),
        .prdata    (cfg_prdata),
        .pslverr   (cfg_pslverr),
        .ratio     (ratio)
    );

    apb_mem_slave u_mem (
        .clock   (clock),
        .reset   (reset),
        .psel    (mem_psel),
        .penable (s_penable),
        .pwrite  (s_pwrite),
        .paddr   (s_paddr),
        .pwdata  (s_pwdata),
        .pstrb   (s_pstrb),
        .pready  (mem_pready),
        .prdata  (mem_prdata),
        .pslverr (mem_pslverr)
    );

endmodule

// ==== bench/apb_subsys_tb.sv ====
module apb_subsys_tb;
    import apb_pkg::*;

    typedef struct packed {
        logic   write;
        paddr_t addr;
        pdata_t data;
        pstrb_t strb;
        logic   rnd;
        logic   exp_err;
        logic   drain;
    } row_t;

    logic   clock;
    logic   reset;
    logic   cmd_valid;
    logic   cmd_write;
    paddr_t cmd_addr;
    pdata_t cmd_wdata;
    pstrb_t cmd_strb;
    logic   cmd_credit;
    logic   rsp_valid;
    pdata_t rsp_rdata;
    logic   rsp_error;

    row_t        rows [$];
    pdata_t      exp_data_q [$];
    logic        exp_err_q [$];
    pdata_t      model_mem [MEM_WORDS];
    ratio_t      model_ratio;
    pdata_t      model_hits;
    int          credits;
    int          cycle_count;
    int          cycle_limit;
    int unsigned seed_value;
    pdata_t      rsp_exp_data;
    logic        rsp_exp_err;

    apb_subsys_top UUT (
        .clock      (clock),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_write  (cmd_write),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .cmd_strb   (cmd_strb),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_error  (rsp_error)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ########################################
    // failure reporting and compares
    // ########################################
    task abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task report_problem(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        abort_run();
    endtask

    task compare_data(input string name, input pdata_t got, input pdata_t exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task verify_error_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // ########################################
    // reference model
    // ########################################
    task automatic apply_model(input row_t r, input pdata_t wdata, output pdata_t exp_data);
        int word;
        word = int'(r.addr[27:2]);
        exp_data = '0;
        // every slow-window transfer is stretched and counted
        if (r.addr[31:28] == SLOW_NIBBLE_LO || r.addr[31:28] == SLOW_NIBBLE_HI) begin
            model_hits = model_hits + 1;
        end
        if (r.addr[31:28] == MEM_BASE[31:28] && word < MEM_WORDS) begin
            if (r.write) begin
                for (int b = 0; b < $bits(pstrb_t); b++) begin
                    if (r.strb[b]) begin
                        model_mem[word][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
            end else begin
                exp_data = model_mem[word];
            end
        end else if (r.addr[31:28] == CFG_BASE[31:28]) begin
            if (r.addr[27:0] == CFG_RATIO_OFS[27:0]) begin
                if (r.write) model_ratio = wdata[7:0];
                else exp_data = pdata_t'(model_ratio);
            end else if (r.addr[27:0] == CFG_HITS_OFS[27:0]) begin
                if (r.write) model_hits = '0;
                else exp_data = model_hits;
            end
        end
    endtask

    // ########################################
    // stimulus
    // ########################################
    task add_row(input logic wr, input paddr_t addr, input pdata_t data, input pstrb_t strb,
                 input logic rnd, input logic exp_err, input logic drain);
        rows.push_back({wr, addr, data, strb, rnd, exp_err, drain});
    endtask

    task load_table();
        // write, address, data, strobes, random data, error, wait for all responses
        add_row(1'b0, 32'h1000_0000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'h1000_0004, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        // full words, four back to back
        add_row(1'b1, 32'hA000_0000, 32'h0, 4'hF, 1'b1, 1'b0, 1'b0);
        add_row(1'b1, 32'hA000_0004, 32'h0, 4'hF, 1'b1, 1'b0, 1'b0);
        add_row(1'b1, 32'hA000_0008, 32'h0, 4'hF, 1'b1, 1'b0, 1'b0);
        add_row(1'b1, 32'hA000_000C, 32'h0, 4'hF, 1'b1, 1'b0, 1'b1);
        add_row(1'b0, 32'hA000_0000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_0004, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_0008, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_000C, 32'h0, 4'h0, 1'b0, 1'b0, 1'b1);
        // partial strobes
        add_row(1'b1, 32'hA000_0000, 32'h0, 4'h5, 1'b1, 1'b0, 1'b0);
        add_row(1'b1, 32'hA000_0004, 32'h0, 4'h8, 1'b1, 1'b0, 1'b0);
        add_row(1'b1, 32'hA000_0008, 32'h0, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(1'b1, 32'hA000_000C, 32'h0, 4'h6, 1'b1, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_0000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_0004, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_0008, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_000C, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 32'hA000_00FC, 32'h0, 4'hF, 1'b1, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_00FC, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        // word 64 and unmapped space
        add_row(1'b1, 32'hA000_0100, 32'h0, 4'hF, 1'b1, 1'b1, 1'b0);
        add_row(1'b0, 32'hA000_0100, 32'h0, 4'h0, 1'b0, 1'b1, 1'b0);
        add_row(1'b1, 32'h5000_0000, 32'h0, 4'hF, 1'b1, 1'b1, 1'b0);
        add_row(1'b0, 32'h5000_0010, 32'h0, 4'h0, 1'b0, 1'b1, 1'b0);
        add_row(1'b0, 32'h1000_0008, 32'h0, 4'h0, 1'b0, 1'b1, 1'b0);
        add_row(1'b0, 32'hA000_0000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_00FC, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        // hit counter
        add_row(1'b0, 32'h1000_0004, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 32'h1000_0004, 32'h0000_DEAD, 4'hF, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'h1000_0004, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 32'hA000_0010, 32'h0, 4'hF, 1'b1, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_0010, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_0004, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'h1000_0000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'h1000_0004, 32'h0, 4'h0, 1'b0, 1'b0, 1'b1);
        // ratio 3 then 1
        add_row(1'b1, 32'h1000_0000, 32'h0000_0003, 4'hF, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'h1000_0000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 32'hA000_0020, 32'h0, 4'hF, 1'b1, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_0020, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 32'h1000_0000, 32'h0000_0001, 4'hF, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'hA000_0020, 32'h0, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 32'h1000_0004, 32'h0, 4'h0, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic send_command(input row_t r);
        pdata_t wdata;
        pdata_t exp_data;
        @(posedge clock);
        #1;
        while (credits == 0) begin
            cmd_valid = 1'b0;
            @(posedge clock);
            #1;
        end
        wdata = r.rnd ? pdata_t'($urandom) : r.data;
        cmd_valid = 1'b1;
        cmd_write = r.write;
        cmd_addr  = r.addr;
        cmd_wdata = wdata;
        cmd_strb  = r.strb;
        credits   = credits - 1;
        apply_model(r, wdata, exp_data);
        exp_data_q.push_back(exp_data);
        exp_err_q.push_back(r.exp_err);
    endtask

    task drain_responses();
        @(posedge clock);
        #1;
        cmd_valid = 1'b0;
        while (exp_err_q.size() != 0) begin
            @(posedge clock);
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clock) begin
        if (!reset) begin
            if (cmd_credit !== rsp_valid) begin
                report_problem("cmd_credit and rsp_valid are not in step");
            end
            if (cmd_credit) begin
                credits = credits + 1;
                if (credits > CMD_DEPTH) report_problem("more credits returned than were spent");
            end
            if (rsp_valid) begin
                if (exp_err_q.size() == 0) begin
                    report_problem("response with no command outstanding");
                end else begin
                    rsp_exp_data = exp_data_q.pop_front();
                    rsp_exp_err  = exp_err_q.pop_front();
                    verify_error_flag("rsp_error", rsp_error, rsp_exp_err);
                    if (!rsp_exp_err) compare_data("rsp_rdata", rsp_rdata, rsp_exp_data);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Error: timeout after %0d cycles, %0d responses outstanding",
                     cycle_count, exp_err_q.size());
            abort_run();
        end
    end

    initial begin
        seed_value  = $urandom(32'ha95e_d39d);
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd_write   = 1'b0;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        cmd_strb    = '0;
        credits     = CMD_DEPTH;
        cycle_count = 0;
        cycle_limit = 0;
        model_ratio = RATIO_RESET;
        model_hits  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        load_table();
        cycle_limit = rows.size() * 80;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            send_command(rows[i]);
            if (rows[i].drain) drain_responses();
        end
        drain_responses();
        repeat (2) @(posedge clock);
        if (credits != CMD_DEPTH) begin
            report_problem("not all credits came back");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
rtl/apb_pkg.sv
rtl/apb_cmd_master.sv
rtl/apb_delayer.sv
rtl/delay_config.sv
rtl/apb_mem_slave.sv
rtl/apb_decoder.sv
rtl/apb_subsys_top.sv
bench/apb_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module apb_subsys_tb \
    -o apb_subsys_sim || exit 1
out=$(./obj_dir/apb_subsys_sim 2>&1)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
